/* Makefile */
TOP = tb_mspi_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

# Output goes to the console, the status comes from the search
run: compile
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

/* design/mspi_avmm_intf.sv */
module mspi_avmm_intf import mspi_pkg::*; (
   input  logic                       avmm_clk,
   input  logic                       avmm_rst_n,
   input  logic                       i_avmm_write,
   input  logic                       i_avmm_read,
   input  logic [AVMM_ADDR_WIDTH-1:0] i_avmm_addr,
   input  mspi_word_t                 i_avmm_wdata,
   input  logic [3:0]                 i_avmm_byte_en,
   output mspi_word_t                 o_avmm_rdata,
   output logic                       o_avmm_rdatavalid,
   output logic                       o_avmm_waitrequest,
   mspi_reg_if.front                  reg_bus
);

   logic [1:0] sm_state;
   logic       accept;
   logic       addr_out_of_range;
   logic       addr_out_of_range_r;

   // Accept cycle is the only one with waitrequest low
   assign accept             = (sm_state == SM_WRITE) || (sm_state == SM_READ);
   assign o_avmm_waitrequest = ~accept;
   assign o_avmm_rdatavalid  = (sm_state == SM_CPL);

   // Any bit above the register index means a miss
   assign addr_out_of_range = |i_avmm_addr[AVMM_ADDR_WIDTH-1:CSR_ADDR_WIDTH];

   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         sm_state            <= SM_IDLE;
         addr_out_of_range_r <= 1'b0;
      end else begin
         // Keep range flag for the completion cycle
         if (accept) begin
            addr_out_of_range_r <= addr_out_of_range;
         end
         case (sm_state)
            SM_IDLE: begin
               // Write wins if both are held
               if (i_avmm_write) begin
                  sm_state <= SM_WRITE;
               end else if (i_avmm_read) begin
                  sm_state <= SM_READ;
               end
            end
            SM_WRITE: sm_state <= SM_IDLE;
            SM_READ:  sm_state <= SM_CPL;
            SM_CPL:   sm_state <= SM_IDLE;
            default:  sm_state <= SM_IDLE;
         endcase
      end
   end

   // Register bus strobes, accept cycle only
   assign reg_bus.write   = (sm_state == SM_WRITE) && !addr_out_of_range;
   assign reg_bus.read    = (sm_state == SM_READ);
   assign reg_bus.address = i_avmm_addr[CSR_ADDR_WIDTH-1:0];
   assign reg_bus.wdata   = i_avmm_wdata;
   assign reg_bus.byte_en = i_avmm_byte_en;

   // Out of range reads complete with zero
   assign o_avmm_rdata = (reg_bus.rdatavalid && !addr_out_of_range_r) ? reg_bus.rdata : '0;

   a_rdv_not_in_accept: assert property (
      @(posedge avmm_clk) disable iff (!avmm_rst_n)
      !(o_avmm_rdatavalid && !o_avmm_waitrequest)
   );

   // Register block must answer in the completion cycle
   a_cpl_has_data: assert property (
      @(posedge avmm_clk) disable iff (!avmm_rst_n)
      (sm_state == SM_CPL) |-> reg_bus.rdatavalid
   );

endmodule

/* design/mspi_csr.sv */
module mspi_csr import mspi_pkg::*; (
   input  logic       avmm_clk,
   input  logic       avmm_rst_n,
   mspi_reg_if.csr    reg_bus,
   output logic       o_start,
   output mspi_byte_t o_div,
   output logic       o_lsb_first,
   output mspi_byte_t o_tx,
   input  logic       i_busy,
   input  logic       i_done,
   input  mspi_byte_t i_rx
);

   mspi_csr_word_u wr_word;
   mspi_csr_word_u ctrl_rd;
   mspi_word_t     div_q;
   mspi_word_t     tx_q;
   mspi_word_t     rd_word;
   mspi_byte_t     rx_q;
   logic           lsb_first_q;
   logic           done_q;
   logic           wr_ctrl;
   logic           wr_div;
   logic           wr_tx;

   // Byte lanes with be set take the new value
   function automatic mspi_word_t merge_bytes(input mspi_word_t cur, input mspi_word_t nxt,
                                              input logic [3:0] be);
      mspi_word_t res;
      res = cur;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) begin
            res[8*i +: 8] = nxt[8*i +: 8];
         end
      end
      return res;
   endfunction

   // ------------------------------------------------------------------------
   // Write decode
   // ------------------------------------------------------------------------

   assign wr_word.raw = reg_bus.wdata;
   assign wr_ctrl     = reg_bus.write && (reg_bus.address == CSR_CTRL);
   assign wr_div      = reg_bus.write && (reg_bus.address == CSR_DIV);
   assign wr_tx       = reg_bus.write && (reg_bus.address == CSR_TXDATA);

   // Start while busy is dropped
   assign o_start = wr_ctrl && wr_word.ctrl.start && !i_busy;

   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         div_q       <= DIV_RESET;
         tx_q        <= '0;
         lsb_first_q <= 1'b0;
         rx_q        <= '0;
         done_q      <= 1'b0;
      end else begin
         if (wr_div) begin
            div_q <= merge_bytes(div_q, reg_bus.wdata, reg_bus.byte_en);
         end
         if (wr_tx) begin
            tx_q <= merge_bytes(tx_q, reg_bus.wdata, reg_bus.byte_en);
         end
         if (wr_ctrl) begin
            lsb_first_q <= wr_word.ctrl.lsb_first;
         end
         if (i_done) begin
            rx_q <= i_rx;
         end
         // Sticky done cleared by the next start
         if (o_start) begin
            done_q <= 1'b0;
         end else if (i_done) begin
            done_q <= 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Read path
   // ------------------------------------------------------------------------

   // CTRL readback with start reading 0
   always_comb begin
      ctrl_rd.raw            = '0;
      ctrl_rd.ctrl.lsb_first = lsb_first_q;
   end

   always_comb begin
      case (reg_bus.address)
         CSR_CTRL:   rd_word = ctrl_rd.raw;
         CSR_DIV:    rd_word = div_q;
         CSR_TXDATA: rd_word = tx_q;
         CSR_RXDATA: rd_word = {24'h0, rx_q};
         CSR_STATUS: rd_word = {30'h0, done_q, i_busy};
         default:    rd_word = '0;
      endcase
   end

   always_ff @(posedge avmm_clk) begin
      if (reg_bus.read) begin
         reg_bus.rdata <= rd_word;
      end
   end

   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         reg_bus.rdatavalid <= 1'b0;
      end else begin
         reg_bus.rdatavalid <= reg_bus.read;
      end
   end

   assign o_div       = div_q[7:0];
   assign o_tx        = tx_q[7:0];
   // Bit order from the same CTRL write reaches the shifter with its start
   assign o_lsb_first = wr_ctrl ? wr_word.ctrl.lsb_first : lsb_first_q;

   a_no_start_when_busy: assert property (
      @(posedge avmm_clk) disable iff (!avmm_rst_n)
      !(o_start && i_busy)
   );

endmodule

/* design/mspi_pkg.sv */
package mspi_pkg;

   // -------------------------------------------------------------------------
   // Address map
   // -------------------------------------------------------------------------

   // Avalon-MM word address and register index widths
   localparam int AVMM_ADDR_WIDTH = 8;
   localparam int CSR_ADDR_WIDTH  = 3;

   // Register indices, 5 to 7 unmapped
   localparam logic [CSR_ADDR_WIDTH-1:0] CSR_CTRL   = 3'd0;
   localparam logic [CSR_ADDR_WIDTH-1:0] CSR_DIV    = 3'd1;
   localparam logic [CSR_ADDR_WIDTH-1:0] CSR_TXDATA = 3'd2;
   localparam logic [CSR_ADDR_WIDTH-1:0] CSR_RXDATA = 3'd3;
   localparam logic [CSR_ADDR_WIDTH-1:0] CSR_STATUS = 3'd4;

   // Bus front end FSM encoding
   localparam logic [1:0] SM_IDLE  = 2'd0;
   localparam logic [1:0] SM_WRITE = 2'd1;
   localparam logic [1:0] SM_READ  = 2'd2;
   localparam logic [1:0] SM_CPL   = 2'd3;

   // Index of the last of 16 SCLK half periods
   localparam logic [3:0] LAST_HALF = 4'd15;

   typedef logic [31:0] mspi_word_t;
   typedef logic [7:0]  mspi_byte_t;

   // CTRL layout, start is write-only
   typedef struct packed {
      logic [29:0] reserved;
      logic        lsb_first;
      logic        start;
   } mspi_ctrl_t;

   // One register word, raw or as CTRL fields
   typedef union packed {
      mspi_word_t raw;
      mspi_ctrl_t ctrl;
   } mspi_csr_word_u;

   localparam mspi_word_t DIV_RESET = 32'd3;

endpackage

/* design/mspi_reg_if.sv */
interface mspi_reg_if import mspi_pkg::*; ();

   // Request side, strobes last one cycle
   logic [CSR_ADDR_WIDTH-1:0] address;
   logic                      read;
   logic                      write;
   mspi_word_t                wdata;
   logic [3:0]                byte_en;

   // Completion side, one cycle after the read strobe
   mspi_word_t                rdata;
   logic                      rdatavalid;

   modport front (
      output address, read, write, wdata, byte_en,
      input  rdata, rdatavalid
   );

   modport csr (
      input  address, read, write, wdata, byte_en,
      output rdata, rdatavalid
   );

endinterface

/* design/mspi_sclk_timer.sv */
module mspi_sclk_timer import mspi_pkg::*; (
   input  logic       avmm_clk,
   input  logic       avmm_rst_n,
   input  logic       i_start,
   input  mspi_byte_t i_div,
   output logic       o_busy,
   output logic       o_rise,
   output logic       o_fall,
   output logic       o_done
);

   mspi_byte_t div_q;
   mspi_byte_t cnt_q;
   logic [3:0] half_q;
   logic       tick;

   // End of a half period, DIV+1 cycles each
   assign tick   = o_busy && (cnt_q == div_q);
   // Even half index ends low phase, odd ends high phase
   assign o_rise = tick && !half_q[0];
   assign o_fall = tick && half_q[0];
   assign o_done = o_fall && (half_q == LAST_HALF);

   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         o_busy <= 1'b0;
         div_q  <= '0;
         cnt_q  <= '0;
         half_q <= '0;
      end else if (!o_busy) begin
         // Divider held for the whole frame
         if (i_start) begin
            o_busy <= 1'b1;
            div_q  <= i_div;
            cnt_q  <= '0;
            half_q <= '0;
         end
      end else if (tick) begin
         cnt_q  <= '0;
         half_q <= half_q + 4'd1;
         if (o_done) begin
            o_busy <= 1'b0;
         end
      end else begin
         cnt_q <= cnt_q + 8'd1;
      end
   end

   a_rise_fall_exclusive: assert property (
      @(posedge avmm_clk) disable iff (!avmm_rst_n)
      !(o_rise && o_fall)
   );

endmodule

/* design/mspi_shifter.sv */
module mspi_shifter import mspi_pkg::*; (
   input  logic       avmm_clk,
   input  logic       avmm_rst_n,
   input  logic       i_start,
   input  mspi_byte_t i_tx,
   input  logic       i_lsb_first,
   input  logic       i_busy,
   input  logic       i_rise,
   input  logic       i_fall,
   output mspi_byte_t o_rx,
   output logic       o_spi_sclk,
   output logic       o_spi_cs_n,
   output logic       o_spi_mosi,
   input  logic       i_spi_miso
);

   mspi_byte_t sh_q;
   mspi_byte_t sh_next;
   logic       load;
   logic       lsb_q;
   logic       miso_q;
   logic       sclk_q;

   // Start is only honoured from idle
   assign load = i_start && !i_busy;

   // Out one end, sampled bit in the other
   assign sh_next = lsb_q ? {miso_q, sh_q[7:1]} : {sh_q[6:0], miso_q};

   always_ff @(posedge avmm_clk or negedge avmm_rst_n) begin
      if (!avmm_rst_n) begin
         lsb_q  <= 1'b0;
         sclk_q <= 1'b0;
      end else begin
         // Bit order fixed for the frame
         if (load) begin
            lsb_q <= i_lsb_first;
         end
         if (i_rise) begin
            sclk_q <= 1'b1;
         end else if (i_fall) begin
            sclk_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge avmm_clk) begin
      if (load) begin
         sh_q <= i_tx;
      end else if (i_fall) begin
         sh_q <= sh_next;
      end
      // Mode 0 sample point
      if (i_rise) begin
         miso_q <= i_spi_miso;
      end
   end

   // Full byte only on the final fall, where done is raised
   assign o_rx = sh_next;

   assign o_spi_sclk = sclk_q;
   assign o_spi_cs_n = ~i_busy;
   // MOSI low while idle
   assign o_spi_mosi = i_busy && (lsb_q ? sh_q[0] : sh_q[7]);

endmodule

/* design/mspi_top.sv */
module mspi_top import mspi_pkg::*; (
   input  logic                       avmm_clk,
   input  logic                       avmm_rst_n,
   input  logic                       i_avmm_write,
   input  logic                       i_avmm_read,
   input  logic [AVMM_ADDR_WIDTH-1:0] i_avmm_addr,
   input  mspi_word_t                 i_avmm_wdata,
   input  logic [3:0]                 i_avmm_byte_en,
   output mspi_word_t                 o_avmm_rdata,
   output logic                       o_avmm_rdatavalid,
   output logic                       o_avmm_waitrequest,
   output logic                       o_spi_sclk,
   output logic                       o_spi_cs_n,
   output logic                       o_spi_mosi,
   input  logic                       i_spi_miso
);

   // Register block to timer and shifter
   logic       start;
   logic       lsb_first;
   mspi_byte_t div;
   mspi_byte_t tx;
   mspi_byte_t rx;

   // Timer outputs
   logic       busy;
   logic       done;
   logic       rise;
   logic       fall;

   mspi_reg_if u_reg_bus ();

   // ------------------------------------------------------------------------
   // Bus side
   // ------------------------------------------------------------------------

   mspi_avmm_intf u_avmm_intf (
      .avmm_clk           (avmm_clk),
      .avmm_rst_n         (avmm_rst_n),
      .i_avmm_write       (i_avmm_write),
      .i_avmm_read        (i_avmm_read),
      .i_avmm_addr        (i_avmm_addr),
      .i_avmm_wdata       (i_avmm_wdata),
      .i_avmm_byte_en     (i_avmm_byte_en),
      .o_avmm_rdata       (o_avmm_rdata),
      .o_avmm_rdatavalid  (o_avmm_rdatavalid),
      .o_avmm_waitrequest (o_avmm_waitrequest),
      .reg_bus            (u_reg_bus.front)
   );

   mspi_csr u_csr (
      .avmm_clk    (avmm_clk),
      .avmm_rst_n  (avmm_rst_n),
      .reg_bus     (u_reg_bus.csr),
      .o_start     (start),
      .o_div       (div),
      .o_lsb_first (lsb_first),
      .o_tx        (tx),
      .i_busy      (busy),
      .i_done      (done),
      .i_rx        (rx)
   );

   // ------------------------------------------------------------------------
   // SPI side
   // ------------------------------------------------------------------------

   mspi_sclk_timer u_sclk_timer (
      .avmm_clk   (avmm_clk),
      .avmm_rst_n (avmm_rst_n),
      .i_start    (start),
      .i_div      (div),
      .o_busy     (busy),
      .o_rise     (rise),
      .o_fall     (fall),
      .o_done     (done)
   );

   mspi_shifter u_shifter (
      .avmm_clk    (avmm_clk),
      .avmm_rst_n  (avmm_rst_n),
      .i_start     (start),
      .i_tx        (tx),
      .i_lsb_first (lsb_first),
      .i_busy      (busy),
      .i_rise      (rise),
      .i_fall      (fall),
      .o_rx        (rx),
      .o_spi_sclk  (o_spi_sclk),
      .o_spi_cs_n  (o_spi_cs_n),
      .o_spi_mosi  (o_spi_mosi),
      .i_spi_miso  (i_spi_miso)
   );

endmodule

/* list.f */
design/mspi_pkg.sv
design/mspi_reg_if.sv
design/mspi_avmm_intf.sv
design/mspi_csr.sv
design/mspi_sclk_timer.sv
design/mspi_shifter.sv
design/mspi_top.sv
tb/tb_mspi_top.sv

/* tb/tb_mspi_top.sv */
module tb_mspi_top import mspi_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 100;
   localparam int RST_CYCLES = 8;
   localparam int TEST_DIV   = 2;
   // Worst case frame at DIV 255 is 16 half periods of 256 cycles
   localparam int WATCHDOG_CYCLES = 20 * 16 * 256 + 2000;
   localparam int POLL_LIMIT      = 1200;

   logic                       avmm_clk;
   logic                       avmm_rst_n;
   logic                       i_avmm_write;
   logic                       i_avmm_read;
   logic [AVMM_ADDR_WIDTH-1:0] i_avmm_addr;
   mspi_word_t                 i_avmm_wdata;
   logic [3:0]                 i_avmm_byte_en;
   mspi_word_t                 o_avmm_rdata;
   logic                       o_avmm_rdatavalid;
   logic                       o_avmm_waitrequest;
   logic                       o_spi_sclk;
   logic                       o_spi_cs_n;
   logic                       o_spi_mosi;
   logic                       i_spi_miso;

   integer seed;
   int     errors;
   int     errors_at_start;
   int     tests_passed;
   int     tests_failed;
   int     rise_count;
   logic   mosi_bits[$];

   mspi_top u_dut (
      .avmm_clk           (avmm_clk),
      .avmm_rst_n         (avmm_rst_n),
      .i_avmm_write       (i_avmm_write),
      .i_avmm_read        (i_avmm_read),
      .i_avmm_addr        (i_avmm_addr),
      .i_avmm_wdata       (i_avmm_wdata),
      .i_avmm_byte_en     (i_avmm_byte_en),
      .o_avmm_rdata       (o_avmm_rdata),
      .o_avmm_rdatavalid  (o_avmm_rdatavalid),
      .o_avmm_waitrequest (o_avmm_waitrequest),
      .o_spi_sclk         (o_spi_sclk),
      .o_spi_cs_n         (o_spi_cs_n),
      .o_spi_mosi         (o_spi_mosi),
      .i_spi_miso         (i_spi_miso)
   );

   // SPI loopback
   assign i_spi_miso = o_spi_mosi;

   always #(CLK_PERIOD / 2) avmm_clk = ~avmm_clk;

   // MOSI is stable at every SCLK rise in mode 0
   always @(posedge o_spi_sclk) begin
      mosi_bits.push_back(o_spi_mosi);
      rise_count++;
   end

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------

   function automatic logic [AVMM_ADDR_WIDTH-1:0] csr_addr(
      input logic [CSR_ADDR_WIDTH-1:0] idx);
      return {{(AVMM_ADDR_WIDTH - CSR_ADDR_WIDTH){1'b0}}, idx};
   endfunction

   function automatic mspi_byte_t next_tx();
      mspi_word_t r;
      r = $random(seed);
      return r[7:0];
   endfunction

   // Rebuild the byte from the MOSI bits in the order they arrived
   function automatic mspi_byte_t mosi_byte(input logic lsb_first);
      mspi_byte_t b;
      b = '0;
      for (int i = 0; i < 8 && i < mosi_bits.size(); i++) begin
         if (lsb_first) begin
            b[i] = mosi_bits[i];
         end else begin
            b[7-i] = mosi_bits[i];
         end
      end
      return b;
   endfunction

   task automatic check_word(input mspi_word_t got, input mspi_word_t exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic check_byte(input mspi_byte_t got, input mspi_byte_t exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   // Request held until the accept cycle
   task automatic avmm_write(input logic [AVMM_ADDR_WIDTH-1:0] addr, input mspi_word_t data,
                             input logic [3:0] be);
      @(negedge avmm_clk);
      i_avmm_write   = 1'b1;
      i_avmm_addr    = addr;
      i_avmm_wdata   = data;
      i_avmm_byte_en = be;
      @(negedge avmm_clk);
      while (o_avmm_waitrequest) @(negedge avmm_clk);
      @(negedge avmm_clk);
      i_avmm_write = 1'b0;
   endtask

   task automatic avmm_read(input logic [AVMM_ADDR_WIDTH-1:0] addr, output mspi_word_t data);
      @(negedge avmm_clk);
      i_avmm_read = 1'b1;
      i_avmm_addr = addr;
      @(negedge avmm_clk);
      while (o_avmm_waitrequest) @(negedge avmm_clk);
      @(negedge avmm_clk);
      while (!o_avmm_rdatavalid) @(negedge avmm_clk);
      data        = o_avmm_rdata;
      i_avmm_read = 1'b0;
   endtask

   task automatic clear_monitor();
      mosi_bits.delete();
      rise_count = 0;
   endtask

   task automatic start_transfer(input mspi_byte_t tx, input logic lsb_first);
      avmm_write(csr_addr(CSR_TXDATA), {24'h0, tx}, 4'hF);
      clear_monitor();
      avmm_write(csr_addr(CSR_CTRL), {30'h0, lsb_first, 1'b1}, 4'hF);
   endtask

   // Poll STATUS for the sticky done bit
   task automatic wait_done();
      mspi_word_t status;
      int         polls;
      status = '0;
      polls  = 0;
      while (!status[1] && polls < POLL_LIMIT) begin
         avmm_read(csr_addr(CSR_STATUS), status);
         polls++;
      end
      if (!status[1]) begin
         $display("error at %0t: transfer not done after %0d status polls", $time, polls);
         errors++;
      end
   endtask

   task automatic check_frame(input mspi_byte_t tx, input logic lsb_first);
      mspi_word_t rd;
      avmm_read(csr_addr(CSR_RXDATA), rd);
      check_word(rd, {24'h0, tx}, "RXDATA after loopback");
      avmm_read(csr_addr(CSR_STATUS), rd);
      check_word(rd, 32'h2, "STATUS after frame");
      check_byte(mspi_byte_t'(rise_count), 8'd8, "SCLK rise count");
      check_byte(mosi_byte(lsb_first), tx, "MOSI bit order");
   endtask

   task automatic begin_test();
      errors_at_start = errors;
   endtask

   task automatic end_test(input string name);
      if (errors == errors_at_start) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - errors_at_start);
      end
   endtask

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------

   task automatic test_reset_values();
      mspi_word_t rd;
      begin_test();
      check_byte({5'b0, o_spi_mosi, o_spi_cs_n, o_spi_sclk}, 8'h02, "idle MOSI, CS_N, SCLK");
      avmm_read(csr_addr(CSR_CTRL), rd);
      check_word(rd, 32'h0, "CTRL reset");
      avmm_read(csr_addr(CSR_DIV), rd);
      check_word(rd, DIV_RESET, "DIV reset");
      avmm_read(csr_addr(CSR_STATUS), rd);
      check_word(rd, 32'h0, "STATUS reset");
      end_test("reset values");
   endtask

   task automatic test_register_access();
      mspi_word_t rd;
      begin_test();
      avmm_write(csr_addr(CSR_DIV), 32'hAABBCC07, 4'b0001);
      avmm_read(csr_addr(CSR_DIV), rd);
      check_word(rd, 32'h00000007, "DIV low byte only");
      avmm_write(csr_addr(CSR_DIV), 32'h11223344, 4'b1010);
      avmm_read(csr_addr(CSR_DIV), rd);
      check_word(rd, 32'h11003307, "DIV bytes 1 and 3");
      avmm_write(csr_addr(CSR_TXDATA), 32'hDEADBEEF, 4'b1111);
      avmm_write(csr_addr(CSR_TXDATA), 32'h00000055, 4'b0001);
      avmm_write(csr_addr(CSR_TXDATA), 32'h00120000, 4'b0100);
      avmm_read(csr_addr(CSR_TXDATA), rd);
      check_word(rd, 32'hDE12BE55, "TXDATA merged bytes");
      // Unmapped indices
      for (int i = 5; i < 8; i++) begin
         avmm_write(AVMM_ADDR_WIDTH'(i), 32'hFFFFFFFF, 4'hF);
         avmm_read(AVMM_ADDR_WIDTH'(i), rd);
         check_word(rd, 32'h0, $sformatf("unmapped index %0d", i));
      end
      end_test("register access");
   endtask

   task automatic test_out_of_range();
      mspi_word_t rd;
      begin_test();
      avmm_write(csr_addr(CSR_DIV), 32'h0000005A, 4'hF);
      // Bit 3 set so the address aliases DIV
      avmm_write(8'h08 | csr_addr(CSR_DIV), 32'hFFFFFFFF, 4'hF);
      avmm_read(csr_addr(CSR_DIV), rd);
      check_word(rd, 32'h0000005A, "DIV after aliased write");
      avmm_read(8'h08 | csr_addr(CSR_DIV), rd);
      check_word(rd, 32'h0, "read at 0x09");
      avmm_read(8'h80 | csr_addr(CSR_DIV), rd);
      check_word(rd, 32'h0, "read at 0x81");
      end_test("out-of-range addresses");
   endtask

   task automatic test_msb_first();
      mspi_byte_t tx;
      begin_test();
      avmm_write(csr_addr(CSR_DIV), TEST_DIV, 4'hF);
      tx = next_tx();
      start_transfer(tx, 1'b0);
      wait_done();
      check_frame(tx, 1'b0);
      end_test("msb-first transfer");
   endtask

   task automatic test_lsb_first();
      mspi_byte_t tx;
      mspi_word_t rd;
      begin_test();
      tx = next_tx();
      start_transfer(tx, 1'b1);
      // Done from the last frame is gone and busy is set
      avmm_read(csr_addr(CSR_STATUS), rd);
      check_word(rd, 32'h1, "STATUS right after start");
      check_byte({7'b0, o_spi_cs_n}, 8'h00, "CS_N low while busy");
      avmm_read(csr_addr(CSR_CTRL), rd);
      check_word(rd, 32'h2, "CTRL readback, start reads 0");
      wait_done();
      check_frame(tx, 1'b1);
      end_test("lsb-first transfer");
   endtask

   task automatic test_start_while_busy();
      mspi_byte_t tx;
      mspi_word_t rd;
      begin_test();
      tx = next_tx();
      start_transfer(tx, 1'b0);
      // New TX byte and a second start in mid frame
      avmm_write(csr_addr(CSR_TXDATA), {24'h0, ~tx}, 4'hF);
      avmm_write(csr_addr(CSR_CTRL), 32'h1, 4'hF);
      wait_done();
      check_frame(tx, 1'b0);
      // One full frame time with nothing on the wire
      repeat (16 * (TEST_DIV + 1) + 20) @(negedge avmm_clk);
      check_byte(mspi_byte_t'(rise_count), 8'd8, "SCLK rises after ignored start");
      avmm_read(csr_addr(CSR_STATUS), rd);
      check_word(rd, 32'h2, "STATUS after ignored start");
      avmm_read(csr_addr(CSR_RXDATA), rd);
      check_word(rd, {24'h0, tx}, "RXDATA after ignored start");
      end_test("start while busy");
   endtask

   // ------------------------------------------------------------------------
   // Main sequence and watchdog
   // ------------------------------------------------------------------------

   initial begin
      avmm_clk       = 1'b0;
      avmm_rst_n     = 1'b0;
      i_avmm_write   = 1'b0;
      i_avmm_read    = 1'b0;
      i_avmm_addr    = '0;
      i_avmm_wdata   = '0;
      i_avmm_byte_en = '0;
      seed           = 85073;
      errors         = 0;
      tests_passed   = 0;
      tests_failed   = 0;
      clear_monitor();
      repeat (RST_CYCLES) @(negedge avmm_clk);
      avmm_rst_n = 1'b1;
      @(negedge avmm_clk);

      test_reset_values();
      test_register_access();
      test_out_of_range();
      test_msb_first();
      test_lsb_first();
      test_start_while_busy();

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: simulation did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule
